/* rtl/fetch_pkg.sv */
package fetch_pkg;

  typedef logic [15:0] word_t;   // data, offset, immediate, pointer
  typedef logic [19:0] paddr_t;  // physical address
  typedef logic [7:0]  byte_t;   // opcode or modrm
  typedef logic [3:0]  reg_t;    // bit 3 selects segment regs
  typedef logic [1:0]  seg_t;    // es cs ss ds
  typedef logic [1:0]  step_t;   // execute step

  typedef enum logic [2:0] {
    opcod_st, modrm_st, offse_st, immed_st, execu_st
  } fetch_state_e;

  typedef enum logic [3:0] {
    seq_nop, seq_pushr, seq_popr, seq_movir, seq_movrr,
    seq_movrm, seq_movmr, seq_lea, seq_movam, seq_jmpi
  } seq_e;

  // execute cycles, indexed by seq_e
  localparam step_t seq_len [10] = '{
    2'd1, 2'd2, 2'd2,        // nop pushr popr
    2'd1, 2'd1, 2'd2,        // movir movrr movrm
    2'd2, 2'd1, 2'd2,        // movmr lea movam
    2'd1                     // jmpi
  };

  localparam reg_t  reg_none = 4'b1100;
  localparam byte_t op_nop   = 8'h90;

  // register codes
  localparam reg_t reg_ax = 4'b0000;
  localparam reg_t reg_bx = 4'b0011;
  localparam reg_t reg_bp = 4'b0101;
  localparam reg_t reg_si = 4'b0110;
  localparam reg_t reg_di = 4'b0111;

  // segment codes
  localparam seg_t seg_ss = 2'b10;
  localparam seg_t seg_ds = 2'b11;

  // fixed immediate and offset sizes
  localparam logic size_byte = 1'b0;
  localparam logic size_word = 1'b1;

  localparam word_t inc_byte = 16'd1;
  localparam word_t inc_word = 16'd2;

endpackage

/* rtl/decode_if.sv */
interface decode_if;

  fetch_pkg::byte_t opcode;  // live or latched
  fetch_pkg::byte_t modrm;

  logic need_modrm;
  logic need_off;
  logic need_imm;
  logic off_size;            // 1 = word
  logic imm_size;            // 1 = word

  modport deco (
    input  opcode, modrm,
    output need_modrm, need_off, need_imm, off_size, imm_size
  );

  modport fsm (
    output opcode, modrm,
    input  need_modrm, need_off, need_imm, off_size, imm_size
  );

endinterface

/* rtl/ea_regs.sv */
module ea_regs (
  input  logic [2:0]       rm_i,
  input  logic [1:0]       mod_i,
  output fetch_pkg::reg_t  base_o,
  output fetch_pkg::reg_t  index_o,
  output fetch_pkg::seg_t  seg_o,
  output logic             direct_o
);

  assign direct_o = (rm_i == 3'b110) && (mod_i == 2'b00);

  always_comb
  begin
    base_o  = fetch_pkg::reg_none;
    index_o = fetch_pkg::reg_none;
    seg_o   = fetch_pkg::seg_ds;
    case (rm_i)
      3'b000:
      begin
        base_o  = fetch_pkg::reg_bx;
        index_o = fetch_pkg::reg_si;
      end
      3'b001:
      begin
        base_o  = fetch_pkg::reg_bx;
        index_o = fetch_pkg::reg_di;
      end
      3'b010:
      begin
        base_o  = fetch_pkg::reg_bp;  // bp based defaults to ss
        index_o = fetch_pkg::reg_si;
        seg_o   = fetch_pkg::seg_ss;
      end
      3'b011:
      begin
        base_o  = fetch_pkg::reg_bp;
        index_o = fetch_pkg::reg_di;
        seg_o   = fetch_pkg::seg_ss;
      end
      3'b100:  index_o = fetch_pkg::reg_si;
      3'b101:  index_o = fetch_pkg::reg_di;
      3'b110:
      begin
        if (!direct_o)
        begin
          base_o = fetch_pkg::reg_bp;
          seg_o  = fetch_pkg::seg_ss;
        end
      end
      default: base_o = fetch_pkg::reg_bx;
    endcase
  end

endmodule

/* rtl/opcode_deco.sv */
module opcode_deco (
  decode_if.deco           dec,
  output fetch_pkg::seq_e  seq_o,
  output fetch_pkg::reg_t  src_o,
  output fetch_pkg::reg_t  dst_o,
  output fetch_pkg::reg_t  base_o,
  output fetch_pkg::reg_t  index_o,
  output fetch_pkg::seg_t  seg_o
);

  logic [1:0] mod;
  logic [2:0] regm;
  logic [2:0] rm;
  logic       dir;
  logic       direct;
  logic       need_off_mod;
  logic       off_size_mod;

  assign mod  = dec.modrm[7:6];
  assign regm = dec.modrm[5:3];
  assign rm   = dec.modrm[2:0];
  assign dir  = dec.opcode[1];  // 1 = reg is destination

  ea_regs u_ea (
    .rm_i     (rm),
    .mod_i    (mod),
    .base_o   (base_o),
    .index_o  (index_o),
    .seg_o    (seg_o),
    .direct_o (direct)
  );

  assign need_off_mod = direct || (mod == 2'b01) || (mod == 2'b10);
  assign off_size_mod = direct || (mod == 2'b10);

  always_comb
  begin
    seq_o          = fetch_pkg::seq_nop;
    dec.need_modrm = 1'b0;
    dec.need_off   = 1'b0;
    dec.need_imm   = 1'b0;
    dec.off_size   = fetch_pkg::size_byte;
    dec.imm_size   = fetch_pkg::size_byte;
    src_o          = fetch_pkg::reg_none;
    dst_o          = fetch_pkg::reg_none;
    casez (dec.opcode)
      8'b0101_0???:  // push reg
      begin
        seq_o = fetch_pkg::seq_pushr;
        src_o = {1'b0, dec.opcode[2:0]};
      end
      8'b0101_1???:  // pop reg
      begin
        seq_o = fetch_pkg::seq_popr;
        dst_o = {1'b0, dec.opcode[2:0]};
      end
      8'b1011_????:  // mov imm->reg, bit 3 is word
      begin
        seq_o        = fetch_pkg::seq_movir;
        dst_o        = {1'b0, dec.opcode[2:0]};
        dec.need_imm = 1'b1;
        dec.imm_size = dec.opcode[3];
      end
      8'b1000_10??:
      begin
        dec.need_modrm = 1'b1;
        dec.off_size   = off_size_mod;
        if (mod == 2'b11)
        begin
          seq_o = fetch_pkg::seq_movrr;
          src_o = {1'b0, dir ? rm : regm};
          dst_o = {1'b0, dir ? regm : rm};
        end
        else if (dir)
        begin
          seq_o        = fetch_pkg::seq_movmr;  // mem -> reg
          dec.need_off = need_off_mod;
          dst_o        = {1'b0, regm};
        end
        else
        begin
          seq_o        = fetch_pkg::seq_movrm;  // reg -> mem
          dec.need_off = need_off_mod;
          src_o        = {1'b0, regm};
        end
      end
      8'b1000_1101:  // lea
      begin
        seq_o          = fetch_pkg::seq_lea;
        dec.need_modrm = 1'b1;
        dec.need_off   = need_off_mod;
        dec.off_size   = off_size_mod;
        src_o          = {1'b0, regm};
      end
      8'b1010_001?:  // mov a->m, always word offset
      begin
        seq_o        = fetch_pkg::seq_movam;
        dec.need_off = 1'b1;
        dec.off_size = fetch_pkg::size_word;
        src_o        = fetch_pkg::reg_ax;
      end
      8'b1110_10?1:  // jmp near e9, jmp short eb
      begin
        seq_o        = fetch_pkg::seq_jmpi;
        dec.need_imm = 1'b1;
        dec.imm_size = ~dec.opcode[1];
      end
      default: ;     // nop and undecoded
    endcase
  end

endmodule

/* rtl/micro_seq.sv */
module micro_seq (
  input  logic             clk,
  input  logic             rst,
  input  logic             exec_i,
  input  fetch_pkg::seq_e  seq_i,
  output fetch_pkg::step_t step_o,
  output logic             end_instr_o
);

  fetch_pkg::step_t step;
  fetch_pkg::step_t last;

  assign last        = fetch_pkg::seq_len[seq_i] - 2'd1;
  assign end_instr_o = exec_i && (step == last);
  assign step_o      = step;

  always_ff @(posedge clk)
  begin
    if (rst || !exec_i || end_instr_o)
      step <= '0;  // ready for the next sequence
    else
      step <= step + 2'd1;
  end

  // step never runs past the sequence
  a_step_range: assert property (
    @(posedge clk) disable iff (rst)
    exec_i |-> (step < fetch_pkg::seq_len[seq_i])
  );

  // sequence id must hold for the whole execute phase
  a_seq_stable: assert property (
    @(posedge clk) disable iff (rst)
    (exec_i && !end_instr_o) |=> (exec_i && $stable(seq_i))
  );

endmodule

/* rtl/fetch_fsm.sv */
module fetch_fsm (
  input  logic             clk,
  input  logic             rst,
  decode_if.fsm            dec,
  input  fetch_pkg::word_t data_i,
  input  logic             end_instr_i,
  output logic             exec_o,
  output logic             bytefetch_o,
  output fetch_pkg::word_t ip_inc_o,
  output fetch_pkg::word_t off_o,
  output fetch_pkg::word_t imm_o
);

  fetch_pkg::fetch_state_e state;
  fetch_pkg::fetch_state_e next_state;
  fetch_pkg::byte_t        opcode_l;
  fetch_pkg::byte_t        modrm_l;
  fetch_pkg::word_t        off_l;
  fetch_pkg::word_t        imm_l;
  fetch_pkg::word_t        field;
  logic                    word_st;

  assign dec.opcode = (state == fetch_pkg::opcod_st) ? data_i[7:0] : opcode_l;
  assign dec.modrm  = (state == fetch_pkg::modrm_st) ? data_i[7:0] : modrm_l;

  assign word_st = ((state == fetch_pkg::offse_st) && dec.off_size) ||
                   ((state == fetch_pkg::immed_st) && dec.imm_size);

  assign exec_o      = (state == fetch_pkg::execu_st);
  assign bytefetch_o = !word_st;
  assign ip_inc_o    = word_st ? fetch_pkg::inc_word : fetch_pkg::inc_byte;
  assign field       = word_st ? data_i : {8'h00, data_i[7:0]};  // zero-extend
  assign off_o       = off_l;
  assign imm_o       = imm_l;

  always_comb
  begin
    next_state = fetch_pkg::execu_st;
    case (state)
      fetch_pkg::opcod_st:
      begin
        if (dec.need_modrm)
          next_state = fetch_pkg::modrm_st;
        else if (dec.need_off)
          next_state = fetch_pkg::offse_st;
        else if (dec.need_imm)
          next_state = fetch_pkg::immed_st;
      end
      fetch_pkg::modrm_st:
      begin
        if (dec.need_off)
          next_state = fetch_pkg::offse_st;  // needs from live modrm
        else if (dec.need_imm)
          next_state = fetch_pkg::immed_st;
      end
      fetch_pkg::offse_st:
      begin
        if (dec.need_imm)
          next_state = fetch_pkg::immed_st;
      end
      fetch_pkg::immed_st: next_state = fetch_pkg::execu_st;
      default:
      begin
        if (!end_instr_i)
          next_state = fetch_pkg::execu_st;
        else
          next_state = fetch_pkg::opcod_st;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= fetch_pkg::execu_st;  // one nop before first fetch
      opcode_l <= fetch_pkg::op_nop;
      off_l    <= '0;
      imm_l    <= '0;
    end
    else
    begin
      state <= next_state;
      case (state)
        fetch_pkg::opcod_st:
        begin
          opcode_l <= data_i[7:0];
          off_l    <= '0;
          imm_l    <= '0;
        end
        fetch_pkg::modrm_st: modrm_l <= data_i[7:0];
        fetch_pkg::offse_st: off_l   <= field;
        fetch_pkg::immed_st: imm_l   <= field;
        default: ;
      endcase
    end
  end

  // word fetch only in the field state the latched bytes ask for
  a_word_fetch: assert property (
    @(posedge clk) disable iff (rst)
    !bytefetch_o |-> ((state == fetch_pkg::offse_st) && dec.need_off) ||
                     ((state == fetch_pkg::immed_st) && dec.need_imm)
  );

endmodule

/* rtl/fetch_top.sv */
module fetch_top (
  input  logic              clk,
  input  logic              rst,
  input  fetch_pkg::word_t  cs_i,
  input  fetch_pkg::word_t  ip_i,
  input  fetch_pkg::word_t  data_i,
  output fetch_pkg::paddr_t pc_o,
  output logic              bytefetch_o,
  output logic              fetch_or_exec_o,
  output fetch_pkg::word_t  ip_inc_o,
  output fetch_pkg::seq_e   seq_o,
  output fetch_pkg::step_t  step_o,
  output fetch_pkg::reg_t   src_o,
  output fetch_pkg::reg_t   dst_o,
  output fetch_pkg::reg_t   base_o,
  output fetch_pkg::reg_t   index_o,
  output fetch_pkg::seg_t   seg_o,
  output fetch_pkg::word_t  off_o,
  output fetch_pkg::word_t  imm_o
);

  logic end_instr;

  decode_if dec_bus ();

  assign pc_o = {cs_i, 4'h0} + {4'h0, ip_i};  // wraps at 1 MB

  fetch_fsm u_fsm (
    .clk         (clk),
    .rst         (rst),
    .dec         (dec_bus.fsm),
    .data_i      (data_i),
    .end_instr_i (end_instr),
    .exec_o      (fetch_or_exec_o),
    .bytefetch_o (bytefetch_o),
    .ip_inc_o    (ip_inc_o),
    .off_o       (off_o),
    .imm_o       (imm_o)
  );

  opcode_deco u_deco (
    .dec     (dec_bus.deco),
    .seq_o   (seq_o),
    .src_o   (src_o),
    .dst_o   (dst_o),
    .base_o  (base_o),
    .index_o (index_o),
    .seg_o   (seg_o)
  );

  micro_seq u_seq (
    .clk         (clk),
    .rst         (rst),
    .exec_i      (fetch_or_exec_o),
    .seq_i       (seq_o),
    .step_o      (step_o),
    .end_instr_o (end_instr)
  );

endmodule

/* verif/tb_fetch.sv */
module tb_fetch;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          max_vec  = 32;
  localparam logic [15:0] start_ip = 16'h0040;

  logic              clk  = 1'b0;
  logic              rst;
  fetch_pkg::word_t  cs_i;
  fetch_pkg::word_t  ip_i = start_ip;
  fetch_pkg::word_t  data_i;
  fetch_pkg::paddr_t pc_o;
  logic              bytefetch_o;
  logic              fetch_or_exec_o;
  fetch_pkg::word_t  ip_inc_o;
  fetch_pkg::seq_e   seq_o;
  fetch_pkg::step_t  step_o;
  fetch_pkg::reg_t   src_o;
  fetch_pkg::reg_t   dst_o;
  fetch_pkg::reg_t   base_o;
  fetch_pkg::reg_t   index_o;
  fetch_pkg::seg_t   seg_o;
  fetch_pkg::word_t  off_o;
  fetch_pkg::word_t  imm_o;

  logic [7:0]  mem [256];          // code window, indexed by the low address byte
  logic [15:0] vec [max_vec][15];  // count, 5 bytes, seq .. cycles
  int          num_vec;
  int          errors;
  int          checks;
  int          failed_tests;
  logic [31:0] rnd_state;
  logic [15:0] next_ip;
  logic        stalled;

  fetch_top dut_i (
    .clk             (clk),
    .rst             (rst),
    .cs_i            (cs_i),
    .ip_i            (ip_i),
    .data_i          (data_i),
    .pc_o            (pc_o),
    .bytefetch_o     (bytefetch_o),
    .fetch_or_exec_o (fetch_or_exec_o),
    .ip_inc_o        (ip_inc_o),
    .seq_o           (seq_o),
    .step_o          (step_o),
    .src_o           (src_o),
    .dst_o           (dst_o),
    .base_o          (base_o),
    .index_o         (index_o),
    .seg_o           (seg_o),
    .off_o           (off_o),
    .imm_o           (imm_o)
  );

  always #5 clk = ~clk;

  // memory answers in the same cycle, low byte first
  always_comb
    data_i = {mem[pc_o[7:0] + 8'd1], mem[pc_o[7:0]]};

  always @(posedge clk)
  begin
    if (rst)
      ip_i <= start_ip;
    else if (!fetch_or_exec_o)
      ip_i <= ip_i + ip_inc_o;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [19:0] phys_addr(input logic [15:0] seg, input logic [15:0] ofs);
    logic [19:0] a;
    a = seg * 20'd16 + ofs;
    return a;
  endfunction

  function automatic logic in_subset(input logic [7:0] op);
    return op == 8'h90 || op[7:4] == 4'h5 || op[7:4] == 4'hb || op[7:2] == 6'b100010 ||
           op == 8'h8d || op == 8'ha2 || op == 8'ha3 || op == 8'he9 || op == 8'heb;
  endfunction

  // execute cycles per sequence id
  function automatic int exec_len(input logic [15:0] seq);
    case (seq)
      16'd1, 16'd2, 16'd5, 16'd6, 16'd8: return 2;
      default: return 1;
    endcase
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst)
      check(pc_o, phys_addr(cs_i, ip_i), "pc_o");
  end

  task load_vectors;
    int fd;
    int r;
    num_vec = 0;
    fd = $fopen("verif/fetch_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the vectors file verif/fetch_vectors.txt");
      errors++;
      return;
    end
    r = 15;
    while (r == 15 && num_vec < max_vec - 1)
    begin
      r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  vec[num_vec][0], vec[num_vec][1], vec[num_vec][2], vec[num_vec][3],
                  vec[num_vec][4], vec[num_vec][5], vec[num_vec][6], vec[num_vec][7],
                  vec[num_vec][8], vec[num_vec][9], vec[num_vec][10], vec[num_vec][11],
                  vec[num_vec][12], vec[num_vec][13], vec[num_vec][14]);
      if (r == 15)
        num_vec++;
    end
    $fclose(fd);
    if (num_vec == 0)
    begin
      $display("no instructions were read from the vectors file");
      errors++;
    end
  endtask

  task place_program;
    logic [15:0] addr;
    logic [7:0]  op;
    int          tries;
    for (int a = 0; a < 256; a++)
    begin
      rnd_state = xorshift(rnd_state);
      mem[a]    = rnd_state[7:0] ^ 8'(a);  // padding
    end
    addr = start_ip;
    for (int i = 0; i < num_vec; i++)
    begin
      for (int b = 0; b < int'(vec[i][0]); b++)
      begin
        mem[addr[7:0]] = vec[i][1 + b][7:0];
        addr++;
      end
    end
    op    = 8'h90;
    tries = 0;
    while (in_subset(op) && tries < 64)
    begin
      rnd_state = xorshift(rnd_state);
      op        = rnd_state[15:8];
      tries++;
    end
    mem[addr[7:0]] = op;  // undecoded opcode, runs as nop
    vec[num_vec] = '{16'd1, 16'(op), 16'h0, 16'h0, 16'h0, 16'h0, 16'h0, 16'hc, 16'hc,
                     16'hf, 16'hf, 16'h0, 16'h0, 16'h0, 16'd2};
    num_vec++;
  endtask

  task run_test(input int t);
    int          fetch;
    int          execs;
    int          words;
    int          err0;
    int          stages;
    logic        word_last;
    logic        exp_word;
    logic [15:0] start;
    err0      = errors;
    start     = ip_i;
    fetch     = 0;
    execs     = 0;
    words     = 0;
    stages    = int'(vec[t][14]) - exec_len(vec[t][6]);
    word_last = (int'(vec[t][0]) - stages) == 1;  // only the last field can be a word
    check(ip_i, next_ip, "start ip");
    while (!fetch_or_exec_o && fetch < 8)
    begin
      fetch++;
      exp_word = word_last && (fetch == stages);
      if (!bytefetch_o)
        words++;
      check(bytefetch_o, !exp_word, "bytefetch_o");
      check(ip_inc_o, exp_word ? 2 : 1, "ip_inc_o");
      @(negedge clk);
    end
    if (!fetch_or_exec_o)
    begin
      $display("test %0d: the instruction never reached execute", t);
      errors++;
      stalled = 1'b1;
      return;
    end
    check(seq_o, vec[t][6], "seq_o");
    check(src_o, vec[t][7], "src_o");
    check(dst_o, vec[t][8], "dst_o");
    if (vec[t][9] != 16'hf)  // f marks an instruction without modrm
    begin
      check(base_o, vec[t][9], "base_o");
      check(index_o, vec[t][10], "index_o");
      check(seg_o, vec[t][11], "seg_o");
    end
    check(off_o, vec[t][12], "off_o");
    check(imm_o, vec[t][13], "imm_o");
    while (fetch_or_exec_o && execs < 4)
    begin
      check(step_o, execs, "step_o");
      execs++;
      @(negedge clk);
    end
    if (fetch_or_exec_o)
    begin
      $display("test %0d: the instruction never left execute", t);
      errors++;
      stalled = 1'b1;
      return;
    end
    check(execs, exec_len(vec[t][6]), "execute cycles");
    check(fetch + execs, vec[t][14], "total cycles");
    check(fetch + words, vec[t][0], "fetched bytes");
    check(16'(ip_i - start), vec[t][0], "ip advance");
    next_ip = next_ip + vec[t][0];  // where the next instruction was placed
    if (errors == err0)
      $display("test %0d op %h: pass", t, vec[t][1][7:0]);
    else
    begin
      $display("test %0d op %h: fail", t, vec[t][1][7:0]);
      failed_tests++;
    end
  endtask

  initial
  begin
    rst          = 1'b1;
    cs_i         = 16'h1000;
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    stalled      = 1'b0;
    next_ip      = start_ip;
    rnd_state    = 32'd54;
    load_vectors();
    place_program();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check(fetch_or_exec_o, 1, "execute after reset");
    check(seq_o, 0, "seq_o after reset");
    check(step_o, 0, "step_o after reset");
    check(off_o, 0, "off_o after reset");
    check(imm_o, 0, "imm_o after reset");
    @(negedge clk);
    check(fetch_or_exec_o, 0, "opcode fetch after the reset nop");
    $display("reset: %s", (errors == 0) ? "pass" : "fail");
    for (int t = 0; t < num_vec && !stalled; t++)
      run_test(t);
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             num_vec, failed_tests, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

/* verif/fetch_vectors.txt */
1 90 00 00 00 00 0 c c f f 0 0000 0000 2
1 50 00 00 00 00 1 0 c f f 0 0000 0000 3
1 57 00 00 00 00 1 7 c f f 0 0000 0000 3
1 5b 00 00 00 00 2 c 3 f f 0 0000 0000 3
1 5e 00 00 00 00 2 c 6 f f 0 0000 0000 3
1 55 00 00 00 00 1 5 c f f 0 0000 0000 3
2 b0 12 00 00 00 3 c 0 f f 0 0000 0012 3
3 b9 34 12 00 00 3 c 1 f f 0 0000 1234 3
2 b2 ff 00 00 00 3 c 2 f f 0 0000 00ff 3
2 89 00 00 00 00 5 0 c 3 6 3 0000 0000 4
3 8b 43 12 00 00 6 c 0 5 7 2 0012 0000 5
4 89 8c 34 12 00 5 1 c c 6 3 1234 0000 5
4 8b 16 78 56 00 6 c 2 c c 3 5678 0000 5
2 89 c3 00 00 00 4 0 3 5 7 2 0000 0000 3
2 8b f7 00 00 00 4 7 6 3 c 3 0000 0000 3
3 88 56 05 00 00 5 2 c 5 c 2 0005 0000 5
4 8a ad dc fe 00 6 c 5 c 7 3 fedc 0000 5
3 8d 58 40 00 00 7 3 c 3 6 3 0040 0000 4
4 8d 3e 00 10 00 7 7 c c c 3 1000 0000 4
2 8d 02 00 00 00 7 0 c 5 6 2 0000 0000 3
3 a2 56 34 00 00 8 0 c f f 0 3456 0000 4
3 a3 cd ab 00 00 8 0 c f f 0 abcd 0000 4
2 eb 10 00 00 00 9 c c f f 0 0000 0010 3
2 eb f0 00 00 00 9 c c f f 0 0000 00f0 3
3 e9 34 12 00 00 9 c c f f 0 0000 1234 3

/* project.f */
rtl/fetch_pkg.sv
rtl/decode_if.sv
rtl/ea_regs.sv
rtl/opcode_deco.sv
rtl/micro_seq.sv
rtl/fetch_fsm.sv
rtl/fetch_top.sv
verif/tb_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch
LOG       ?= sim.log
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
